// File: filelist.f
+incdir+include
src/rv_isa_pkg.sv
src/id_ctrl_pkg.sv
src/rv_decoder.sv
src/operand_fetch.sv
src/id_ex_stage.sv
src/id_stage.sv
testbench/id_stage_chk.sv
testbench/id_stage_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= id_stage_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
RUN_ARGS  ?= +verilator+error+limit+1000

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard include/*.svh)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) $(RUN_ARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "STATUS: FAIL" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: testbench/id_stage_tb.sv
////////////////////////////////////////
// Decode stage testbench
////////////////////////////////////////

`timescale 1ns/1ns

module id_stage_tb;

  localparam int WAIT_LIMIT = 20;

  logic        clk;
  logic        rst_n;
  logic [31:0] instr_i;
  logic [31:0] pc_i;
  logic        if_valid_i;
  logic        ex_ready_i;
  logic        fw_ex_we_i;
  logic [4:0]  fw_ex_waddr_i;
  logic [31:0] fw_ex_wdata_i;
  logic        wb_we_i;
  logic [4:0]  wb_waddr_i;
  logic [31:0] wb_wdata_i;
  logic        id_ready_o;
  logic        id_valid_o;
  logic [31:0] jump_target_o;
  logic        illegal_insn_o;
  rv_isa_pkg::alu_op_e alu_operator_ex_o;
  logic [31:0] alu_operand_a_ex_o;
  logic [31:0] alu_operand_b_ex_o;
  logic [31:0] store_data_ex_o;
  logic [4:0]  regfile_waddr_ex_o;
  logic        regfile_we_ex_o;
  logic        data_req_ex_o;
  logic        data_we_ex_o;
  rv_isa_pkg::jump_e jump_in_ex_o;

  int          seed = 1;
  int          value_errs = 0;
  int          timeouts = 0;
  int          assert_errs;
  logic [31:0] rf_model [32];
  logic [31:0] rnd;
  logic [31:0] joff;
  logic [31:0] jal_instr;

  id_stage DUT (.*);

  // 8 ns clock
  always #4 clk = ~clk;

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
    else
    begin
      value_errs++;
      $display("FAIL %s got %h expected %h", name, got, exp);
    end
  endtask

  // Register write through WB, model follows
  task automatic wb_write(input logic [4:0] addr, input logic [31:0] data);
    @(posedge clk);
    wb_we_i    <= 1'b1;
    wb_waddr_i <= addr;
    wb_wdata_i <= data;
    @(posedge clk);
    wb_we_i    <= 1'b0;
    rf_model[addr] = data;
  endtask

  // Present an instruction, return at the negedge where it is accepted
  task automatic send(input logic [31:0] instr, input logic [31:0] pc,
                      input logic ex_we, input logic [4:0] ex_addr, input logic [31:0] ex_data,
                      input logic wb_we, input logic [4:0] wb_addr, input logic [31:0] wb_data);
    int cnt;
    @(posedge clk);
    instr_i       <= instr;
    pc_i          <= pc;
    if_valid_i    <= 1'b1;
    fw_ex_we_i    <= ex_we;
    fw_ex_waddr_i <= ex_addr;
    fw_ex_wdata_i <= ex_data;
    wb_we_i       <= wb_we;
    wb_waddr_i    <= wb_addr;
    wb_wdata_i    <= wb_data;
    @(negedge clk);
    cnt = 0;
    while (!id_valid_o && cnt < WAIT_LIMIT)
    begin
      @(negedge clk);
      cnt++;
    end
    if (!id_valid_o)
    begin
      timeouts++;
      $display("ERROR: instruction %h was never accepted", instr);
    end
    if (wb_we && wb_addr != 5'd0)
      rf_model[wb_addr] = wb_data;
  endtask

  // Take the instruction, go idle, stop at the next negedge
  task automatic retire();
    @(posedge clk);
    if_valid_i <= 1'b0;
    fw_ex_we_i <= 1'b0;
    wb_we_i    <= 1'b0;
    @(negedge clk);
  endtask

  initial
  begin
    clk           = 1'b0;
    rst_n         = 1'b0;
    instr_i       = 32'h0000_0013;
    pc_i          = '0;
    if_valid_i    = 1'b0;
    ex_ready_i    = 1'b1;
    fw_ex_we_i    = 1'b0;
    fw_ex_waddr_i = '0;
    fw_ex_wdata_i = '0;
    wb_we_i       = 1'b0;
    wb_waddr_i    = '0;
    wb_wdata_i    = '0;
    for (int i = 0; i < 32; i++)
      rf_model[i] = '0;

    repeat (3) @(posedge clk);
    rst_n <= 1'b1;

    // Random register contents
    for (int r = 1; r < 9; r++)
    begin
      rnd = $random(seed);
      wb_write(r[4:0], rnd);
    end

    // ADDI x9, x1, -3
    send({12'hffd, 5'd1, 3'b000, 5'd9, 7'h13}, 32'h100, 0, 0, 0, 0, 0, 0);
    retire();
    check_value("alu_operand_a_ex_o", alu_operand_a_ex_o, rf_model[1]);
    check_value("alu_operand_b_ex_o", alu_operand_b_ex_o, 32'hffff_fffd);
    check_value("regfile_waddr_ex_o", 32'(regfile_waddr_ex_o), 32'd9);
    check_value("regfile_we_ex_o", 32'(regfile_we_ex_o), 32'd1);

    // SUB x10, x2, x3
    send({7'h20, 5'd3, 5'd2, 3'b000, 5'd10, 7'h33}, 32'h104, 0, 0, 0, 0, 0, 0);
    retire();
    check_value("alu_operand_a_ex_o", alu_operand_a_ex_o, rf_model[2]);
    check_value("alu_operand_b_ex_o", alu_operand_b_ex_o, rf_model[3]);
    check_value("alu_operator_ex_o", 32'(alu_operator_ex_o), 32'(rv_isa_pkg::ALU_SUB));
    check_value("store_data_ex_o", store_data_ex_o, rf_model[3]);
    check_value("regfile_waddr_ex_o", 32'(regfile_waddr_ex_o), 32'd10);
    check_value("regfile_we_ex_o", 32'(regfile_we_ex_o), 32'd1);

    ////////////////////////////////////////
    // Forwarding
    ////////////////////////////////////////
    send({7'h00, 5'd5, 5'd4, 3'b000, 5'd11, 7'h33}, 32'h108,
         1, 5'd4, 32'hcafe_0001, 1, 5'd4, 32'hbeef_0002);
    retire();
    check_value("alu_operand_a_ex_o", alu_operand_a_ex_o, 32'hcafe_0001);

    send({7'h00, 5'd5, 5'd6, 3'b000, 5'd11, 7'h33}, 32'h10c,
         0, 0, 0, 1, 5'd6, 32'h1234_5678);
    retire();
    check_value("alu_operand_a_ex_o", alu_operand_a_ex_o, 32'h1234_5678);

    // x0 is never forwarded
    send({7'h00, 5'd5, 5'd0, 3'b000, 5'd12, 7'h33}, 32'h110,
         1, 5'd0, 32'hdead_beef, 0, 0, 0);
    retire();
    check_value("alu_operand_a_ex_o", alu_operand_a_ex_o, 32'h0);

    // LW x7, 0(x1) directly followed by a user of x7
    send({12'h000, 5'd1, 3'b010, 5'd7, 7'h03}, 32'h114, 0, 0, 0, 0, 0, 0);
    send({7'h00, 5'd2, 5'd7, 3'b000, 5'd13, 7'h33}, 32'h118, 0, 0, 0, 0, 0, 0);
    retire();
    check_value("alu_operand_a_ex_o", alu_operand_a_ex_o, rf_model[7]);
    check_value("regfile_waddr_ex_o", 32'(regfile_waddr_ex_o), 32'd13);

    ////////////////////////////////////////
    // Back-pressure
    ////////////////////////////////////////
    send({7'h00, 5'd8, 5'd3, 3'b111, 5'd14, 7'h33}, 32'h11c, 0, 0, 0, 0, 0, 0);
    @(posedge clk);
    ex_ready_i <= 1'b0;
    // Different instruction waits in ID while EX is held
    instr_i    <= {7'h00, 5'd2, 5'd1, 3'b110, 5'd15, 7'h33};
    repeat (4) @(posedge clk);
    ex_ready_i <= 1'b1;
    if_valid_i <= 1'b0;
    @(negedge clk);

    // JAL with a random even offset
    rnd       = $random(seed);
    joff      = {{11{rnd[20]}}, rnd[20:1], 1'b0};
    jal_instr = {joff[20], joff[10:1], joff[11], joff[19:12], 5'd1, 7'h6f};
    send(jal_instr, 32'h0000_1000, 0, 0, 0, 0, 0, 0);
    check_value("jump_target_o", jump_target_o, 32'h0000_1000 + joff);
    retire();

    // Unknown opcode
    send(32'h0000_007f, 32'h120, 0, 0, 0, 0, 0, 0);
    check_value("illegal_insn_o", 32'(illegal_insn_o), 32'd1);
    retire();
    check_value("regfile_we_ex_o", 32'(regfile_we_ex_o), 32'd0);
    check_value("data_req_ex_o", 32'(data_req_ex_o), 32'd0);

    repeat (2) @(posedge clk);
    assert_errs = DUT.chk_i.fail_count;
    $display("Errors: %0d value, %0d assertion, %0d timeout",
             value_errs, assert_errs, timeouts);
    if (value_errs + assert_errs + timeouts == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

// File: testbench/id_stage_chk.sv
////////////////////////////////////////
// Decode stage protocol checks
////////////////////////////////////////

`timescale 1ns/1ns
`include "id_settings.svh"

module id_stage_chk
(
  input logic                   clk,
  input logic                   rst_n,
  input logic [`XLEN-1:0]       instr_i,
  input logic                   ex_ready_i,
  input logic                   rs1_used,
  input logic                   rs2_used,
  input logic                   id_ready_o,
  input logic                   id_valid_o,
  input logic                   illegal_insn_o,
  input rv_isa_pkg::alu_op_e    alu_operator_ex_o,
  input logic [`XLEN-1:0]       alu_operand_a_ex_o,
  input logic [`XLEN-1:0]       alu_operand_b_ex_o,
  input logic [`XLEN-1:0]       store_data_ex_o,
  input logic [`REG_ADDR_W-1:0] regfile_waddr_ex_o,
  input logic                   regfile_we_ex_o,
  input logic                   data_req_ex_o,
  input logic                   data_we_ex_o,
  input rv_isa_pkg::jump_e      jump_in_ex_o
);

  int   fail_count = 0;
  logic ex_idle;
  logic load_match;

  // EX register carries nothing with side effects
  assign ex_idle = !regfile_we_ex_o && !data_req_ex_o && !data_we_ex_o &&
                   (jump_in_ex_o == rv_isa_pkg::JUMP_NONE);

  // Load in EX feeding a used source
  assign load_match = data_req_ex_o && !data_we_ex_o && (regfile_waddr_ex_o != '0) &&
                      ((rs1_used && (instr_i[`RS1_MSB:`RS1_LSB] == regfile_waddr_ex_o)) ||
                       (rs2_used && (instr_i[`RS2_MSB:`RS2_LSB] == regfile_waddr_ex_o)));

  ////////////////////////////////////////
  // Reset values
  ////////////////////////////////////////
  reset_idle_a: assert property (@(posedge clk) !rst_n |-> ex_idle)
    else begin $error("EX controls active during reset"); fail_count++; end

  reset_exit_a: assert property (@(posedge clk) $rose(rst_n) |-> ex_idle)
    else begin $error("EX controls active after reset release"); fail_count++; end

  ////////////////////////////////////////
  // Stall, bubble and hold
  ////////////////////////////////////////
  load_stall_a: assert property (@(posedge clk) disable iff (!rst_n)
    load_match |-> !id_ready_o && !id_valid_o)
    else begin $error("Load-use hazard not stalled"); fail_count++; end

  bubble_a: assert property (@(posedge clk) disable iff (!rst_n)
    (!id_valid_o && ex_ready_i) |=> ex_idle)
    else begin $error("No bubble after empty cycle"); fail_count++; end

  hold_a: assert property (@(posedge clk) disable iff (!rst_n)
    !ex_ready_i |=> $stable(alu_operator_ex_o) && $stable(alu_operand_a_ex_o) &&
                    $stable(alu_operand_b_ex_o) && $stable(store_data_ex_o) &&
                    $stable(regfile_waddr_ex_o) && $stable(regfile_we_ex_o) &&
                    $stable(data_req_ex_o) && $stable(data_we_ex_o) &&
                    $stable(jump_in_ex_o))
    else begin $error("EX outputs changed under back-pressure"); fail_count++; end

  // Illegal instruction leaves no write or memory access
  illegal_a: assert property (@(posedge clk) disable iff (!rst_n)
    (id_valid_o && illegal_insn_o) |=> !regfile_we_ex_o && !data_req_ex_o)
    else begin $error("Illegal instruction reached EX with side effects"); fail_count++; end

endmodule

bind id_stage id_stage_chk chk_i (.*);

// File: src/id_stage.sv
////////////////////////////////////////
// Instruction decode stage
////////////////////////////////////////

`timescale 1ns/1ns
`include "id_settings.svh"

module id_stage
(
  input  logic                   clk,
  input  logic                   rst_n,

  // From IF
  input  logic [`XLEN-1:0]       instr_i,
  input  logic [`XLEN-1:0]       pc_i,
  input  logic                   if_valid_i,

  // From EX
  input  logic                   ex_ready_i,
  input  logic                   fw_ex_we_i,
  input  logic [`REG_ADDR_W-1:0] fw_ex_waddr_i,
  input  logic [`XLEN-1:0]       fw_ex_wdata_i,

  // From WB
  input  logic                   wb_we_i,
  input  logic [`REG_ADDR_W-1:0] wb_waddr_i,
  input  logic [`XLEN-1:0]       wb_wdata_i,

  output logic                   id_ready_o,
  output logic                   id_valid_o,
  output logic [`XLEN-1:0]       jump_target_o,
  output logic                   illegal_insn_o,

  // To EX
  output rv_isa_pkg::alu_op_e    alu_operator_ex_o,
  output logic [`XLEN-1:0]       alu_operand_a_ex_o,
  output logic [`XLEN-1:0]       alu_operand_b_ex_o,
  output logic [`XLEN-1:0]       store_data_ex_o,
  output logic [`REG_ADDR_W-1:0] regfile_waddr_ex_o,
  output logic                   regfile_we_ex_o,
  output logic                   data_req_ex_o,
  output logic                   data_we_ex_o,
  output rv_isa_pkg::jump_e      jump_in_ex_o
);

  // Decoder controls
  rv_isa_pkg::alu_op_e    alu_op;
  id_ctrl_pkg::op_a_sel_e op_a_sel;
  id_ctrl_pkg::op_b_sel_e op_b_sel;
  id_ctrl_pkg::jt_sel_e   jt_sel;
  logic [`XLEN-1:0]       imm;
  logic                   rs1_used;
  logic                   rs2_used;
  logic                   rf_we;
  logic                   data_req;
  logic                   data_we;
  rv_isa_pkg::jump_e      jump;

  // Forwarded register values
  logic [`XLEN-1:0]       rs1_data;
  logic [`XLEN-1:0]       rs2_data;

  rv_decoder decoder_i
  (
    .instr_i    ( instr_i        ),
    .alu_op_o   ( alu_op         ),
    .op_a_sel_o ( op_a_sel       ),
    .op_b_sel_o ( op_b_sel       ),
    .jt_sel_o   ( jt_sel         ),
    .imm_o      ( imm            ),
    .rs1_used_o ( rs1_used       ),
    .rs2_used_o ( rs2_used       ),
    .rf_we_o    ( rf_we          ),
    .data_req_o ( data_req       ),
    .data_we_o  ( data_we        ),
    .illegal_o  ( illegal_insn_o ),
    .jump_o     ( jump           )
  );

  operand_fetch operand_fetch_i
  (
    .clk           ( clk           ),
    .rst_n         ( rst_n         ),
    .instr_i       ( instr_i       ),
    .wb_we_i       ( wb_we_i       ),
    .wb_waddr_i    ( wb_waddr_i    ),
    .wb_wdata_i    ( wb_wdata_i    ),
    .fw_ex_we_i    ( fw_ex_we_i    ),
    .fw_ex_waddr_i ( fw_ex_waddr_i ),
    .fw_ex_wdata_i ( fw_ex_wdata_i ),
    .rs1_data_o    ( rs1_data      ),
    .rs2_data_o    ( rs2_data      )
  );

  id_ex_stage id_ex_stage_i
  (
    .clk                ( clk                ),
    .rst_n              ( rst_n              ),
    .instr_i            ( instr_i            ),
    .pc_i               ( pc_i               ),
    .if_valid_i         ( if_valid_i         ),
    .ex_ready_i         ( ex_ready_i         ),
    .alu_op_i           ( alu_op             ),
    .op_a_sel_i         ( op_a_sel           ),
    .op_b_sel_i         ( op_b_sel           ),
    .jt_sel_i           ( jt_sel             ),
    .imm_i              ( imm                ),
    .rs1_used_i         ( rs1_used           ),
    .rs2_used_i         ( rs2_used           ),
    .rf_we_i            ( rf_we              ),
    .data_req_i         ( data_req           ),
    .data_we_i          ( data_we            ),
    .jump_i             ( jump               ),
    .rs1_data_i         ( rs1_data           ),
    .rs2_data_i         ( rs2_data           ),
    .jump_target_o      ( jump_target_o      ),
    .id_ready_o         ( id_ready_o         ),
    .id_valid_o         ( id_valid_o         ),
    .alu_operator_ex_o  ( alu_operator_ex_o  ),
    .alu_operand_a_ex_o ( alu_operand_a_ex_o ),
    .alu_operand_b_ex_o ( alu_operand_b_ex_o ),
    .store_data_ex_o    ( store_data_ex_o    ),
    .regfile_waddr_ex_o ( regfile_waddr_ex_o ),
    .regfile_we_ex_o    ( regfile_we_ex_o    ),
    .data_req_ex_o      ( data_req_ex_o      ),
    .data_we_ex_o       ( data_we_ex_o       ),
    .jump_in_ex_o       ( jump_in_ex_o       )
  );

endmodule

// File: src/id_ex_stage.sv
////////////////////////////////////////
// Operand select and ID/EX register
////////////////////////////////////////

`timescale 1ns/1ns
`include "id_settings.svh"

module id_ex_stage
(
  input  logic                       clk,
  input  logic                       rst_n,

  input  logic [`XLEN-1:0]           instr_i,
  input  logic [`XLEN-1:0]           pc_i,
  input  logic                       if_valid_i,
  input  logic                       ex_ready_i,

  // From decoder
  input  rv_isa_pkg::alu_op_e        alu_op_i,
  input  id_ctrl_pkg::op_a_sel_e     op_a_sel_i,
  input  id_ctrl_pkg::op_b_sel_e     op_b_sel_i,
  input  id_ctrl_pkg::jt_sel_e       jt_sel_i,
  input  logic [`XLEN-1:0]           imm_i,
  input  logic                       rs1_used_i,
  input  logic                       rs2_used_i,
  input  logic                       rf_we_i,
  input  logic                       data_req_i,
  input  logic                       data_we_i,
  input  rv_isa_pkg::jump_e          jump_i,

  // Forwarded operands
  input  logic [`XLEN-1:0]           rs1_data_i,
  input  logic [`XLEN-1:0]           rs2_data_i,

  output logic [`XLEN-1:0]           jump_target_o,
  output logic                       id_ready_o,
  output logic                       id_valid_o,

  // ID/EX register
  output rv_isa_pkg::alu_op_e        alu_operator_ex_o,
  output logic [`XLEN-1:0]           alu_operand_a_ex_o,
  output logic [`XLEN-1:0]           alu_operand_b_ex_o,
  output logic [`XLEN-1:0]           store_data_ex_o,
  output logic [`REG_ADDR_W-1:0]     regfile_waddr_ex_o,
  output logic                       regfile_we_ex_o,
  output logic                       data_req_ex_o,
  output logic                       data_we_ex_o,
  output rv_isa_pkg::jump_e          jump_in_ex_o
);

  logic [`REG_ADDR_W-1:0] rs1_addr;
  logic [`REG_ADDR_W-1:0] rs2_addr;
  logic [`REG_ADDR_W-1:0] rd_addr;
  logic [`XLEN-1:0]       alu_operand_a;
  logic [`XLEN-1:0]       alu_operand_b;
  logic                   load_in_ex;
  logic                   load_stall;

  assign rs1_addr = instr_i[`RS1_MSB:`RS1_LSB];
  assign rs2_addr = instr_i[`RS2_MSB:`RS2_LSB];
  assign rd_addr  = instr_i[`RD_MSB:`RD_LSB];

  // Operand A mux
  always_comb
  begin
    case (op_a_sel_i)
      id_ctrl_pkg::OP_A_PC:   alu_operand_a = pc_i;
      id_ctrl_pkg::OP_A_ZERO: alu_operand_a = '0;
      default:                alu_operand_a = rs1_data_i;
    endcase
  end

  // Operand B mux
  always_comb
  begin
    case (op_b_sel_i)
      id_ctrl_pkg::OP_B_IMM:    alu_operand_b = imm_i;
      id_ctrl_pkg::OP_B_PCINCR: alu_operand_b = `XLEN'(`PC_INCR);
      default:                  alu_operand_b = rs2_data_i;
    endcase
  end

  // Jump target, decoder already picked the immediate format
  always_comb
  begin
    case (jt_sel_i)
      id_ctrl_pkg::JT_JALR: jump_target_o = rs1_data_i + imm_i;
      default:              jump_target_o = pc_i + imm_i;
    endcase
  end

  ////////////////////////////////////////
  // Load-use stall
  ////////////////////////////////////////
  assign load_in_ex = data_req_ex_o && !data_we_ex_o && (regfile_waddr_ex_o != '0);
  assign load_stall = load_in_ex &&
                      ((rs1_used_i && (rs1_addr == regfile_waddr_ex_o)) ||
                       (rs2_used_i && (rs2_addr == regfile_waddr_ex_o)));

  assign id_ready_o = !load_stall && ex_ready_i;
  assign id_valid_o = if_valid_i && id_ready_o;

  ////////////////////////////////////////
  // ID/EX pipeline register
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      alu_operator_ex_o  <= rv_isa_pkg::ALU_ADD;
      alu_operand_a_ex_o <= '0;
      alu_operand_b_ex_o <= '0;
      store_data_ex_o    <= '0;
      regfile_waddr_ex_o <= '0;
      regfile_we_ex_o    <= 1'b0;
      data_req_ex_o      <= 1'b0;
      data_we_ex_o       <= 1'b0;
      jump_in_ex_o       <= rv_isa_pkg::JUMP_NONE;
    end
    else if (id_valid_o)
    begin
      alu_operator_ex_o  <= alu_op_i;
      alu_operand_a_ex_o <= alu_operand_a;
      alu_operand_b_ex_o <= alu_operand_b;
      store_data_ex_o    <= rs2_data_i;
      regfile_waddr_ex_o <= rd_addr;
      regfile_we_ex_o    <= rf_we_i;
      data_req_ex_o      <= data_req_i;
      data_we_ex_o       <= data_we_i;
      jump_in_ex_o       <= jump_i;
    end
    else if (ex_ready_i)
    begin
      // Bubble, payload left as is
      regfile_we_ex_o    <= 1'b0;
      data_req_ex_o      <= 1'b0;
      data_we_ex_o       <= 1'b0;
      jump_in_ex_o       <= rv_isa_pkg::JUMP_NONE;
    end
  end

endmodule

// File: src/operand_fetch.sv
////////////////////////////////////////
// Register file with forwarding
////////////////////////////////////////

`timescale 1ns/1ns
`include "id_settings.svh"

module operand_fetch
(
  input  logic                   clk,
  input  logic                   rst_n,

  input  logic [`XLEN-1:0]       instr_i,

  // Write back, writes the array and forwards
  input  logic                   wb_we_i,
  input  logic [`REG_ADDR_W-1:0] wb_waddr_i,
  input  logic [`XLEN-1:0]       wb_wdata_i,

  // EX result forward
  input  logic                   fw_ex_we_i,
  input  logic [`REG_ADDR_W-1:0] fw_ex_waddr_i,
  input  logic [`XLEN-1:0]       fw_ex_wdata_i,

  output logic [`XLEN-1:0]       rs1_data_o,
  output logic [`XLEN-1:0]       rs2_data_o
);

  logic [`XLEN-1:0]       regs [`NUM_REGS];

  // Index 0 is rs1, index 1 is rs2
  logic [`REG_ADDR_W-1:0] raddr [2];
  id_ctrl_pkg::fw_sel_e   fw_sel [2];
  logic [`XLEN-1:0]       rdata [2];

  assign raddr[0] = instr_i[`RS1_MSB:`RS1_LSB];
  assign raddr[1] = instr_i[`RS2_MSB:`RS2_LSB];

  // Array write, x0 stays zero
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < `NUM_REGS; i++)
        regs[i] <= '0;
    end
    else if (wb_we_i && (wb_waddr_i != '0))
    begin
      regs[wb_waddr_i] <= wb_wdata_i;
    end
  end

  // Forward select, EX wins over WB
  always_comb
  begin
    for (int p = 0; p < 2; p++)
    begin
      fw_sel[p] = id_ctrl_pkg::FW_REGFILE;
      if (raddr[p] != '0)
      begin
        if (fw_ex_we_i && (fw_ex_waddr_i == raddr[p]))
          fw_sel[p] = id_ctrl_pkg::FW_EX;
        else if (wb_we_i && (wb_waddr_i == raddr[p]))
          fw_sel[p] = id_ctrl_pkg::FW_WB;
      end
    end
  end

  // Operand muxes
  always_comb
  begin
    for (int p = 0; p < 2; p++)
    begin
      case (fw_sel[p])
        id_ctrl_pkg::FW_EX: rdata[p] = fw_ex_wdata_i;
        id_ctrl_pkg::FW_WB: rdata[p] = wb_wdata_i;
        default:            rdata[p] = regs[raddr[p]];
      endcase
    end
  end

  assign rs1_data_o = rdata[0];
  assign rs2_data_o = rdata[1];

endmodule

// File: src/rv_decoder.sv
////////////////////////////////////////
// RV32I instruction decoder
////////////////////////////////////////

`timescale 1ns/1ns
`include "id_settings.svh"

module rv_decoder
(
  input  logic [`XLEN-1:0]       instr_i,

  output rv_isa_pkg::alu_op_e    alu_op_o,
  output id_ctrl_pkg::op_a_sel_e op_a_sel_o,
  output id_ctrl_pkg::op_b_sel_e op_b_sel_o,
  output id_ctrl_pkg::jt_sel_e   jt_sel_o,
  output logic [`XLEN-1:0]       imm_o,

  output logic                   rs1_used_o,
  output logic                   rs2_used_o,
  output logic                   rf_we_o,
  output logic                   data_req_o,
  output logic                   data_we_o,
  output logic                   illegal_o,
  output rv_isa_pkg::jump_e      jump_o
);

  rv_isa_pkg::opcode_e opcode;
  logic [2:0]          funct3;
  logic [6:0]          funct7;

  logic [`XLEN-1:0]    imm_i_type;
  logic [`XLEN-1:0]    imm_s_type;
  logic [`XLEN-1:0]    imm_b_type;
  logic [`XLEN-1:0]    imm_u_type;
  logic [`XLEN-1:0]    imm_j_type;

  assign opcode = rv_isa_pkg::opcode_e'(instr_i[`OPC_MSB:`OPC_LSB]);
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  ////////////////////////////////////////
  // Immediates, sign bit is instr[31]
  ////////////////////////////////////////
  assign imm_i_type = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s_type = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b_type = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                       instr_i[30:25], instr_i[11:8], 1'b0};
  assign imm_u_type = {instr_i[31:12], 12'b0};
  assign imm_j_type = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12],
                       instr_i[20], instr_i[30:21], 1'b0};

  ////////////////////////////////////////
  // Control decode
  ////////////////////////////////////////
  always_comb
  begin
    // Defaults describe an I-type add
    alu_op_o   = rv_isa_pkg::ALU_ADD;
    op_a_sel_o = id_ctrl_pkg::OP_A_REG;
    op_b_sel_o = id_ctrl_pkg::OP_B_IMM;
    jt_sel_o   = id_ctrl_pkg::JT_JAL;
    imm_o      = imm_i_type;
    rs1_used_o = 1'b0;
    rs2_used_o = 1'b0;
    rf_we_o    = 1'b0;
    data_req_o = 1'b0;
    data_we_o  = 1'b0;
    illegal_o  = 1'b0;
    jump_o     = rv_isa_pkg::JUMP_NONE;

    case (opcode)
      rv_isa_pkg::OPC_LUI:
      begin
        op_a_sel_o = id_ctrl_pkg::OP_A_ZERO;
        imm_o      = imm_u_type;
        rf_we_o    = 1'b1;
      end

      rv_isa_pkg::OPC_AUIPC:
      begin
        op_a_sel_o = id_ctrl_pkg::OP_A_PC;
        imm_o      = imm_u_type;
        rf_we_o    = 1'b1;
      end

      rv_isa_pkg::OPC_JAL:
      begin
        // Link value pc + 4 through the ALU
        op_a_sel_o = id_ctrl_pkg::OP_A_PC;
        op_b_sel_o = id_ctrl_pkg::OP_B_PCINCR;
        imm_o      = imm_j_type;
        rf_we_o    = 1'b1;
        jump_o     = rv_isa_pkg::JUMP_JAL;
      end

      rv_isa_pkg::OPC_JALR:
      begin
        op_a_sel_o = id_ctrl_pkg::OP_A_PC;
        op_b_sel_o = id_ctrl_pkg::OP_B_PCINCR;
        jt_sel_o   = id_ctrl_pkg::JT_JALR;
        rs1_used_o = 1'b1;
        rf_we_o    = 1'b1;
        jump_o     = rv_isa_pkg::JUMP_JAL;
        illegal_o  = (funct3 != 3'b000);
      end

      rv_isa_pkg::OPC_BRANCH:
      begin
        // Comparison in ALU, target from pc + B imm
        op_b_sel_o = id_ctrl_pkg::OP_B_REG;
        jt_sel_o   = id_ctrl_pkg::JT_COND;
        imm_o      = imm_b_type;
        rs1_used_o = 1'b1;
        rs2_used_o = 1'b1;
        jump_o     = rv_isa_pkg::JUMP_BRANCH;
        case (funct3)
          3'b000:  alu_op_o = rv_isa_pkg::ALU_EQ;
          3'b001:  alu_op_o = rv_isa_pkg::ALU_NE;
          3'b100:  alu_op_o = rv_isa_pkg::ALU_LT;
          3'b101:  alu_op_o = rv_isa_pkg::ALU_GE;
          3'b110:  alu_op_o = rv_isa_pkg::ALU_LTU;
          3'b111:  alu_op_o = rv_isa_pkg::ALU_GEU;
          default: illegal_o = 1'b1;
        endcase
      end

      rv_isa_pkg::OPC_LOAD:
      begin
        rs1_used_o = 1'b1;
        rf_we_o    = 1'b1;
        data_req_o = 1'b1;
        // LB LH LW LBU LHU only
        illegal_o  = (funct3 == 3'b011) || (funct3[2:1] == 2'b11);
      end

      rv_isa_pkg::OPC_STORE:
      begin
        imm_o      = imm_s_type;
        rs1_used_o = 1'b1;
        rs2_used_o = 1'b1;
        data_req_o = 1'b1;
        data_we_o  = 1'b1;
        illegal_o  = (funct3 > 3'b010);
      end

      rv_isa_pkg::OPC_OP_IMM:
      begin
        rs1_used_o = 1'b1;
        rf_we_o    = 1'b1;
        case (funct3)
          3'b000: alu_op_o = rv_isa_pkg::ALU_ADD;
          3'b010: alu_op_o = rv_isa_pkg::ALU_SLT;
          3'b011: alu_op_o = rv_isa_pkg::ALU_SLTU;
          3'b100: alu_op_o = rv_isa_pkg::ALU_XOR;
          3'b110: alu_op_o = rv_isa_pkg::ALU_OR;
          3'b111: alu_op_o = rv_isa_pkg::ALU_AND;
          3'b001:
          begin
            alu_op_o  = rv_isa_pkg::ALU_SLL;
            illegal_o = (funct7 != 7'h00);
          end
          default:
          begin
            // Shift right, funct7 picks logical or arithmetic
            alu_op_o  = funct7[5] ? rv_isa_pkg::ALU_SRA : rv_isa_pkg::ALU_SRL;
            illegal_o = (funct7 != 7'h00) && (funct7 != 7'h20);
          end
        endcase
      end

      rv_isa_pkg::OPC_OP:
      begin
        op_b_sel_o = id_ctrl_pkg::OP_B_REG;
        rs1_used_o = 1'b1;
        rs2_used_o = 1'b1;
        rf_we_o    = 1'b1;
        case ({funct7, funct3})
          {7'h00, 3'b000}: alu_op_o = rv_isa_pkg::ALU_ADD;
          {7'h20, 3'b000}: alu_op_o = rv_isa_pkg::ALU_SUB;
          {7'h00, 3'b001}: alu_op_o = rv_isa_pkg::ALU_SLL;
          {7'h00, 3'b010}: alu_op_o = rv_isa_pkg::ALU_SLT;
          {7'h00, 3'b011}: alu_op_o = rv_isa_pkg::ALU_SLTU;
          {7'h00, 3'b100}: alu_op_o = rv_isa_pkg::ALU_XOR;
          {7'h00, 3'b101}: alu_op_o = rv_isa_pkg::ALU_SRL;
          {7'h20, 3'b101}: alu_op_o = rv_isa_pkg::ALU_SRA;
          {7'h00, 3'b110}: alu_op_o = rv_isa_pkg::ALU_OR;
          {7'h00, 3'b111}: alu_op_o = rv_isa_pkg::ALU_AND;
          default:         illegal_o = 1'b1;
        endcase
      end

      default: illegal_o = 1'b1;
    endcase

    // Illegal instruction has no side effects
    if (illegal_o)
    begin
      rf_we_o    = 1'b0;
      data_req_o = 1'b0;
      data_we_o  = 1'b0;
      jump_o     = rv_isa_pkg::JUMP_NONE;
    end
  end

endmodule

// File: src/id_ctrl_pkg.sv
////////////////////////////////////////
// Decode datapath control types
////////////////////////////////////////

package id_ctrl_pkg;

  // Operand A source
  typedef enum logic [1:0] {
    OP_A_REG  = 2'b00,
    OP_A_PC   = 2'b01,
    OP_A_ZERO = 2'b10
  } op_a_sel_e;

  // Operand B source
  typedef enum logic [1:0] {
    OP_B_REG    = 2'b00,
    OP_B_IMM    = 2'b01,
    OP_B_PCINCR = 2'b10
  } op_b_sel_e;

  // Jump target base and offset
  typedef enum logic [1:0] {
    JT_JAL  = 2'b00,  // pc + J imm
    JT_JALR = 2'b01,  // rs1 + I imm
    JT_COND = 2'b10   // pc + B imm
  } jt_sel_e;

  // Operand forwarding source
  typedef enum logic [1:0] {
    FW_REGFILE = 2'b00,
    FW_EX      = 2'b01,
    FW_WB      = 2'b10
  } fw_sel_e;

endpackage

// File: src/rv_isa_pkg.sv
////////////////////////////////////////
// RV32I instruction set types
////////////////////////////////////////

package rv_isa_pkg;

  // Major opcodes handled by the decoder
  typedef enum logic [6:0] {
    OPC_LOAD   = 7'h03,
    OPC_OP_IMM = 7'h13,
    OPC_AUIPC  = 7'h17,
    OPC_STORE  = 7'h23,
    OPC_OP     = 7'h33,
    OPC_LUI    = 7'h37,
    OPC_BRANCH = 7'h63,
    OPC_JALR   = 7'h67,
    OPC_JAL    = 7'h6f
  } opcode_e;

  // ALU operations, comparisons for branches
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLL  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9,
    ALU_EQ   = 4'd10,
    ALU_NE   = 4'd11,
    ALU_LT   = 4'd12,
    ALU_GE   = 4'd13,
    ALU_LTU  = 4'd14,
    ALU_GEU  = 4'd15
  } alu_op_e;

  // Kind of control transfer
  typedef enum logic [1:0] {
    JUMP_NONE   = 2'b00,
    JUMP_JAL    = 2'b01,  // JAL and JALR
    JUMP_BRANCH = 2'b10
  } jump_e;

endpackage

// File: include/id_settings.svh
////////////////////////////////////////
// Decode stage widths and fields
////////////////////////////////////////

`ifndef ID_SETTINGS_SVH
`define ID_SETTINGS_SVH

// Datapath and register file
`define XLEN       32
`define REG_ADDR_W 5
`define NUM_REGS   32

// Instruction field positions
`define RS1_MSB 19
`define RS1_LSB 15
`define RS2_MSB 24
`define RS2_LSB 20
`define RD_MSB  11
`define RD_LSB  7
`define OPC_MSB 6
`define OPC_LSB 0

// Link address increment, no compressed support
`define PC_INCR 4

`endif
